// ==== dv/cache_tb.sv ====
/*
 * Testbench for the split cache subsystem.
 * A reference copy of both caches predicts misses and read data; flush,
 * clear, bypass and concurrent misses are checked against it.
 */

`timescale 1ns/100ps
`default_nettype none

module cache_tb;

    localparam int          N_RAND    = 150;
    localparam int          TOTAL_OPS = 260;
    localparam logic [31:0] SEED      = 32'h1e38;

    logic             CLK;
    logic             arst_n;
    cache_pkg::addr_t iaddr, daddr, mem_addr;
    cache_pkg::word_t irdata, drdata, dwdata, mem_wdata, mem_rdata;
    logic             iren, ibusy, dren, dwen, dbusy;
    logic             iflush, iclear, dflush, dclear;
    logic             iflush_done, iclear_done, dflush_done, dclear_done;
    logic             icache_miss, dcache_miss, mem_ren, mem_wen, mem_busy;

    // reference state where index 0 is the instruction cache.
    logic             ref_valid [2][16];
    logic             ref_dirty [2][16];
    cache_pkg::tag_t  ref_tag   [2][16];
    cache_pkg::word_t ref_data  [2][16];
    cache_pkg::word_t mem_ref   [cache_pkg::addr_t];
    cache_pkg::word_t golden    [cache_pkg::addr_t];
    logic [31:0]      rng;
    int               mem_writes = 0;

    cache_subsystem_top dut_i (.*);

    tb_mem_model #(.SEED(SEED)) mem_i (.*);

    function automatic cache_pkg::word_t init_word(input cache_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic cache_pkg::word_t mem_value(input cache_pkg::addr_t a);
        return mem_ref.exists(a) ? mem_ref[a] : init_word(a);
    endfunction

    task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("MISMATCH t=%0t %s actual=%h expected=%h", $time, name, act, exp);
            $display("=== FAIL ===");
            $fatal(1, "value check failed");
        end
    endtask

    // write completions seen on the memory bus.
    always @(negedge CLK) begin
        if (mem_wen && !mem_busy) begin
            mem_writes++;
        end
    end

    task automatic predict_access(input int side, input logic wr, input cache_pkg::addr_t a,
                                  input cache_pkg::word_t wd, output logic exp_miss,
                                  output cache_pkg::word_t exp_data);
        int idx;
        idx      = a[5:2];
        exp_miss = 1'b0;
        if (a >= cache_pkg::NONCACHE_START_ADDR) begin
            if (wr) begin
                mem_ref[a] = wd;
                golden[a]  = wd;
            end
            exp_data = mem_value(a);
        end else begin
            exp_miss = !(ref_valid[side][idx] && ref_tag[side][idx] == a[31:6]);
            if (exp_miss) begin
                if (ref_valid[side][idx] && ref_dirty[side][idx]) begin
                    mem_ref[{ref_tag[side][idx], a[5:2], 2'b00}] = ref_data[side][idx];
                end
                ref_valid[side][idx] = 1'b1;
                ref_dirty[side][idx] = 1'b0;
                ref_tag[side][idx]   = a[31:6];
                ref_data[side][idx]  = mem_value(a);
            end
            if (wr) begin
                ref_data[side][idx]  = wd;
                ref_dirty[side][idx] = 1'b1;
                golden[a]            = wd;
            end
            exp_data = ref_data[side][idx];
        end
    endtask

    // one instruction read and/or one data access, issued in the same cycle.
    task automatic run_access(input logic use_i, input logic use_d, input logic wr,
                              input cache_pkg::addr_t ia, input cache_pkg::addr_t da,
                              input cache_pkg::word_t wd);
        logic             i_exp_miss, d_exp_miss, i_pend, d_pend;
        cache_pkg::word_t i_exp, d_exp, i_got, d_got;
        int               i_misses, d_misses, i_cycles, d_cycles;
        i_pend   = use_i;
        d_pend   = use_d;
        i_misses = 0;
        d_misses = 0;
        i_cycles = 0;
        d_cycles = 0;
        if (use_i) predict_access(0, 1'b0, ia, '0, i_exp_miss, i_exp);
        if (use_d) predict_access(1, wr, da, wd, d_exp_miss, d_exp);
        @(posedge CLK);
        #0.5;
        iaddr  = ia;
        iren   = use_i;
        daddr  = da;
        dwdata = wd;
        dren   = use_d && !wr;
        dwen   = use_d && wr;
        while (i_pend || d_pend) begin
            @(negedge CLK);
            if (i_pend) begin
                i_misses += icache_miss;
                i_cycles++;
                if (!ibusy) begin
                    i_got  = irdata;
                    i_pend = 1'b0;
                end
            end
            if (d_pend) begin
                d_misses += dcache_miss;
                d_cycles++;
                if (!dbusy) begin
                    d_got  = drdata;
                    d_pend = 1'b0;
                end
            end
            @(posedge CLK);
            #0.5;
            if (!i_pend) iren = 1'b0;
            if (!d_pend) begin
                dren = 1'b0;
                dwen = 1'b0;
            end
        end
        if (use_i) begin
            check("icache_miss", i_misses, i_exp_miss);
            check("irdata", i_got, i_exp);
            // a hit answers in the cycle of the request.
            if (!i_exp_miss) check("ibusy_cycles", i_cycles, 1);
        end
        if (use_d) begin
            check("dcache_miss", d_misses, d_exp_miss);
            if (!wr) check("drdata", d_got, d_exp);
            if (!d_exp_miss && da < cache_pkg::NONCACHE_START_ADDR) begin
                check("dbusy_cycles", d_cycles, 1);
            end
        end
    endtask

    // flush or clear one cache and wait for its done pulse.
    task automatic control_op(input int side, input logic is_flush);
        logic done;
        int   writes_before;
        int   dirty_lines;
        writes_before = mem_writes;
        dirty_lines   = 0;
        @(posedge CLK);
        #0.5;
        iflush = (side == 0) && is_flush;
        iclear = (side == 0) && !is_flush;
        dflush = (side == 1) && is_flush;
        dclear = (side == 1) && !is_flush;
        @(posedge CLK);
        #0.5;
        {iflush, iclear, dflush, dclear} = '0;
        done = 1'b0;
        while (!done) begin
            @(negedge CLK);
            done = (side == 0) ? (is_flush ? iflush_done : iclear_done)
                               : (is_flush ? dflush_done : dclear_done);
        end
        for (int i = 0; i < 16; i++) begin
            if (is_flush && ref_valid[side][i] && ref_dirty[side][i]) begin
                mem_ref[{ref_tag[side][i], 4'(i), 2'b00}] = ref_data[side][i];
                dirty_lines++;
            end
            ref_dirty[side][i] = 1'b0;
            if (!is_flush) ref_valid[side][i] = 1'b0;
        end
        // a flush writes back each dirty line once and a clear writes nothing.
        check("mem_writes", mem_writes - writes_before, dirty_lines);
        // data not yet written back is gone after a clear.
        if (side == 1 && !is_flush) begin
            foreach (golden[a]) golden[a] = mem_value(a);
        end
    endtask

    task automatic memory_matches_golden();
        cache_pkg::word_t w;
        foreach (golden[a]) begin
            mem_i.read_word(a, w);
            check("mem_word", w, golden[a]);
        end
    endtask

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    initial begin
        #(TOTAL_OPS * 40 * 4);
        $display("timeout: the run did not finish within %0d cycles", TOTAL_OPS * 40);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    initial begin
        cache_pkg::word_t w;
        logic [31:0]      r;
        rng       = SEED;
        arst_n    = 1'b0;
        {iren, dren, dwen, iflush, iclear, dflush, dclear} = '0;
        iaddr     = '0;
        daddr     = '0;
        dwdata    = '0;
        for (int i = 0; i < 16; i++) begin
            {ref_valid[0][i], ref_valid[1][i], ref_dirty[0][i], ref_dirty[1][i]} = '0;
        end
        repeat (5) @(posedge CLK);
        #0.5;
        arst_n = 1'b1;

        // the first pass of instruction reads misses and the second hits.
        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 8; k++) run_access(1, 0, 0, 32'h1000 + k * 4, '0, '0);
        end
        run_access(1, 0, 0, 32'h1040, '0, '0);
        run_access(1, 0, 0, 32'h1000, '0, '0);

        // the instruction cache holds no dirty line to write back.
        control_op(0, 1'b1);

        // random data traffic over 64 words mapped onto 16 lines.
        for (int n = 0; n < N_RAND; n++) begin
            rng = xorshift32(rng);
            r   = rng;
            rng = xorshift32(rng);
            run_access(0, 1, r[8], '0, 32'h4000 + (r % 64) * 4, rng);
        end

        control_op(1, 1'b1);
        memory_matches_golden();
        // with no writes in between, a second flush finds no dirty line.
        control_op(1, 1'b1);

        // non-cacheable region.
        for (int k = 0; k < 6; k++) begin
            run_access(0, 1, 1, '0, 32'h8000_0100 + k * 8, 32'hc0de_0000 + k);
            mem_i.read_word(32'h8000_0100 + k * 8, w);
            check("mem_bypass_write", w, 32'hc0de_0000 + k);
        end
        for (int k = 0; k < 12; k++) run_access(0, 1, 0, '0, 32'h8000_0100 + k * 4, '0);

        // clears drop unflushed data and force misses.
        for (int k = 0; k < 4; k++) run_access(0, 1, 1, '0, 32'h4000 + k * 4, 32'hdead_0000 + k);
        control_op(1, 1'b0);
        for (int k = 0; k < 4; k++) run_access(0, 1, 0, '0, 32'h4000 + k * 4, '0);
        run_access(1, 0, 0, 32'h1004, '0, '0);
        control_op(0, 1'b0);
        run_access(1, 0, 0, 32'h1004, '0, '0);

        // simultaneous misses on both sides where the data side has dirty victims.
        for (int k = 0; k < 8; k++) run_access(0, 1, 1, '0, 32'h4000 + k * 4, 32'hbeef_0000 + k);
        for (int k = 0; k < 8; k++) begin
            run_access(1, 1, 0, 32'h1100 + k * 4, 32'h4800 + k * 4, '0);
        end
        control_op(1, 1'b1);
        memory_matches_golden();

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_mem_model.sv ====
/*
 * Behavioral word memory on the external bus of the cache subsystem.
 * Each transaction completes after 1 to 4 cycles of random latency.
 * Unwritten words read as the testbench fill pattern; read_word is a backdoor.
 */

`timescale 1ns/100ps
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'h1e38
) (
    input  logic             CLK,
    input  logic             arst_n,
    input  cache_pkg::addr_t mem_addr,
    input  cache_pkg::word_t mem_wdata,
    input  logic             mem_ren,
    input  logic             mem_wen,
    output cache_pkg::word_t mem_rdata,
    output logic             mem_busy
);

    cache_pkg::word_t mem [cache_pkg::addr_t];
    logic [31:0]      rng;
    int               lat;
    int               wait_cnt;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic read_word(input cache_pkg::addr_t a, output cache_pkg::word_t w);
        w = mem.exists(a) ? mem[a] : cache_tb.init_word(a);
    endtask

    // busy is high except in the single completion cycle.
    always @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            mem_busy  <= 1'b1;
            mem_rdata <= '0;
            wait_cnt  <= 0;
            rng        = xorshift32(SEED);
            lat        = 1 + (rng % 4);
        end else if (!mem_busy) begin
            mem_busy <= 1'b1;
            wait_cnt <= 0;
        end else if (mem_ren || mem_wen) begin
            if (wait_cnt + 1 >= lat) begin
                mem_busy  <= 1'b0;
                mem_rdata <= mem.exists(mem_addr) ? mem[mem_addr] : cache_tb.init_word(mem_addr);
                if (mem_wen) begin
                    mem[mem_addr] = mem_wdata;
                end
                rng = xorshift32(rng);
                lat = 1 + (rng % 4);
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end else begin
            wait_cnt <= 0;
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/cache_pkg.sv
logic/generic_bus_if.sv
logic/cache_control_if.sv
logic/direct_mapped_cache.sv
logic/separate_caches.sv
logic/mem_arbiter.sv
logic/cache_subsystem_top.sv
dv/tb_mem_model.sv
dv/cache_tb.sv

// ==== logic/cache_control_if.sv ====
/*
 * Flush and clear strobes from the cache controller and their done pulses.
 * One interface serves both the instruction and the data cache.
 */

`timescale 1ns/100ps
`default_nettype none

interface cache_control_if;

    logic icache_flush, icache_clear;
    logic dcache_flush, dcache_clear;
    logic iflush_done, iclear_done;
    logic dflush_done, dclear_done;

    modport controller (
        output icache_flush, icache_clear, dcache_flush, dcache_clear,
        input  iflush_done, iclear_done, dflush_done, dclear_done
    );

    modport caches (
        input  icache_flush, icache_clear, dcache_flush, dcache_clear,
        output iflush_done, iclear_done, dflush_done, dclear_done
    );

endinterface

`default_nettype wire

// ==== logic/cache_pkg.sv ====
/*
 * Shared widths, cache geometry and state encoding for the split L1 caches.
 * Every RTL file refers to these definitions by scoped name.
 */

`default_nettype none

package cache_pkg;

    localparam int ADDR_BITS   = 32;
    localparam int WORD_BITS   = 32;
    localparam int OFFSET_BITS = 2;
    localparam int LINES       = 16;
    localparam int INDEX_BITS  = $clog2(LINES);
    localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    typedef logic [ADDR_BITS-1:0]  addr_t;
    typedef logic [WORD_BITS-1:0]  word_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   tag_t;

    // everything from here up goes straight to memory.
    localparam addr_t NONCACHE_START_ADDR = 32'h8000_0000;

    typedef enum logic [2:0] {
        IDLE,
        WRITEBACK,
        FILL,
        FLUSH_SCAN,
        FLUSH_WB,
        BYPASS,
        FLUSH_DONE
    } cache_state_t;

endpackage

`default_nettype wire

// ==== logic/cache_subsystem_top.sv ====
/*
 * Top level of the split cache subsystem.
 * Maps the core, control and memory ports onto bus interfaces and connects
 * the cache pair to the memory arbiter.
 */

`timescale 1ns/100ps
`default_nettype none

module cache_subsystem_top (
    input  logic             CLK,
    input  logic             arst_n,
    input  cache_pkg::addr_t iaddr,
    input  logic             iren,
    output cache_pkg::word_t irdata,
    output logic             ibusy,
    input  cache_pkg::addr_t daddr,
    input  cache_pkg::word_t dwdata,
    input  logic             dren,
    input  logic             dwen,
    output cache_pkg::word_t drdata,
    output logic             dbusy,
    input  logic             iflush,
    input  logic             iclear,
    input  logic             dflush,
    input  logic             dclear,
    output logic             iflush_done,
    output logic             iclear_done,
    output logic             dflush_done,
    output logic             dclear_done,
    output logic             icache_miss,
    output logic             dcache_miss,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::word_t mem_wdata,
    output logic             mem_ren,
    output logic             mem_wen,
    input  cache_pkg::word_t mem_rdata,
    input  logic             mem_busy
);

    generic_bus_if icache_proc_bus ();
    generic_bus_if dcache_proc_bus ();
    generic_bus_if icache_mem_bus ();
    generic_bus_if dcache_mem_bus ();
    generic_bus_if mem_bus ();
    cache_control_if control ();

    // instruction fetch is read only.
    assign icache_proc_bus.addr  = iaddr;
    assign icache_proc_bus.wdata = '0;
    assign icache_proc_bus.ren   = iren;
    assign icache_proc_bus.wen   = 1'b0;
    assign irdata                = icache_proc_bus.rdata;
    assign ibusy                 = icache_proc_bus.busy;

    assign dcache_proc_bus.addr  = daddr;
    assign dcache_proc_bus.wdata = dwdata;
    assign dcache_proc_bus.ren   = dren;
    assign dcache_proc_bus.wen   = dwen;
    assign drdata                = dcache_proc_bus.rdata;
    assign dbusy                 = dcache_proc_bus.busy;

    assign control.icache_flush = iflush;
    assign control.icache_clear = iclear;
    assign control.dcache_flush = dflush;
    assign control.dcache_clear = dclear;
    assign iflush_done          = control.iflush_done;
    assign iclear_done          = control.iclear_done;
    assign dflush_done          = control.dflush_done;
    assign dclear_done          = control.dclear_done;

    assign mem_addr      = mem_bus.addr;
    assign mem_wdata     = mem_bus.wdata;
    assign mem_ren       = mem_bus.ren;
    assign mem_wen       = mem_bus.wen;
    assign mem_bus.rdata = mem_rdata;
    assign mem_bus.busy  = mem_busy;

    separate_caches caches_i (
        .CLK             (CLK),
        .arst_n          (arst_n),
        .icache_proc_bus (icache_proc_bus),
        .dcache_proc_bus (dcache_proc_bus),
        .icache_mem_bus  (icache_mem_bus),
        .dcache_mem_bus  (dcache_mem_bus),
        .control         (control),
        .icache_miss     (icache_miss),
        .dcache_miss     (dcache_miss)
    );

    mem_arbiter arbiter_i (
        .CLK            (CLK),
        .arst_n         (arst_n),
        .icache_mem_bus (icache_mem_bus),
        .dcache_mem_bus (dcache_mem_bus),
        .mem_bus        (mem_bus)
    );

endmodule

`default_nettype wire

// ==== logic/direct_mapped_cache.sv ====
/*
 * Direct-mapped, write-back, write-allocate cache with one word per line.
 * Hits answer in the request cycle; misses pulse cache_miss and go to memory.
 * Addresses at or above the non-cacheable boundary bypass the line array.
 */

`timescale 1ns/100ps
`default_nettype none

module direct_mapped_cache (
    input  logic                   CLK,
    input  logic                   arst_n,
    generic_bus_if.generic_bus     proc_bus,
    generic_bus_if.cpu             mem_bus,
    input  logic                   flush,
    input  logic                   clear,
    output logic                   flush_done,
    output logic                   clear_done,
    output logic                   cache_miss
);

    cache_pkg::cache_state_t state, next_state;

    logic [cache_pkg::LINES-1:0] valid;
    logic [cache_pkg::LINES-1:0] dirty;
    cache_pkg::tag_t             tags_q [cache_pkg::LINES];
    cache_pkg::word_t            data_q [cache_pkg::LINES];

    cache_pkg::index_t line_cnt, cnt_next;
    logic              cnt_last;

    cache_pkg::index_t req_idx;
    cache_pkg::tag_t   req_tag;
    cache_pkg::index_t wb_idx;
    logic              req;
    logic              noncache;
    logic              hit;
    logic              victim_dirty;
    logic              mem_done;

    // single write port into the line array.
    logic              upd_en;
    cache_pkg::index_t upd_idx;
    cache_pkg::tag_t   upd_tag;
    cache_pkg::word_t  upd_data;
    logic              upd_dirty;

    logic             byp_ready;
    logic             byp_take;
    logic             byp_capture;
    cache_pkg::word_t byp_data;

    assign req_idx  = proc_bus.addr[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];
    assign req_tag  = proc_bus.addr[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];
    assign req      = proc_bus.ren | proc_bus.wen;
    assign noncache = proc_bus.addr >= cache_pkg::NONCACHE_START_ADDR;
    assign hit      = valid[req_idx] && (tags_q[req_idx] == req_tag);
    assign mem_done = !mem_bus.busy;
    assign cnt_last = line_cnt == cache_pkg::index_t'(cache_pkg::LINES - 1);

    assign victim_dirty = valid[req_idx] && dirty[req_idx];

    // victim of a demand miss, or the line under the flush walk.
    assign wb_idx = (state == cache_pkg::FLUSH_WB) ? line_cnt : req_idx;

    assign byp_take    = (state == cache_pkg::IDLE) && req && noncache;
    assign byp_capture = (state == cache_pkg::BYPASS) && mem_done;
    assign flush_done  = state == cache_pkg::FLUSH_DONE;

    always_comb begin
        next_state     = state;
        cnt_next       = line_cnt;
        proc_bus.busy  = 1'b1;
        proc_bus.rdata = data_q[req_idx];
        mem_bus.addr   = proc_bus.addr;
        mem_bus.wdata  = proc_bus.wdata;
        mem_bus.ren    = 1'b0;
        mem_bus.wen    = 1'b0;
        cache_miss     = 1'b0;
        upd_en         = 1'b0;
        upd_idx        = req_idx;
        upd_tag        = req_tag;
        upd_data       = proc_bus.wdata;
        upd_dirty      = 1'b1;

        case (state)
            cache_pkg::IDLE: begin
                if (flush) begin
                    next_state = cache_pkg::FLUSH_SCAN;
                    cnt_next   = '0;
                end else if (req && noncache) begin
                    if (byp_ready) begin
                        proc_bus.busy  = 1'b0;
                        proc_bus.rdata = byp_data;
                    end else begin
                        next_state = cache_pkg::BYPASS;
                    end
                end else if (req) begin
                    cache_miss = !hit;
                    // a write into a clean victim allocates without memory traffic.
                    if (hit || (proc_bus.wen && !victim_dirty)) begin
                        proc_bus.busy = 1'b0;
                        upd_en        = proc_bus.wen;
                    end else if (victim_dirty) begin
                        next_state = cache_pkg::WRITEBACK;
                    end else begin
                        next_state = cache_pkg::FILL;
                    end
                end
            end
            cache_pkg::WRITEBACK: begin
                mem_bus.addr  = {tags_q[wb_idx], wb_idx, 2'b00};
                mem_bus.wdata = data_q[wb_idx];
                mem_bus.wen   = 1'b1;
                if (mem_done) begin
                    // a write installs here, so the retry in IDLE is a hit.
                    upd_en     = proc_bus.wen;
                    next_state = proc_bus.wen ? cache_pkg::IDLE : cache_pkg::FILL;
                end
            end
            cache_pkg::FILL: begin
                mem_bus.ren = 1'b1;
                if (mem_done) begin
                    upd_en     = 1'b1;
                    upd_data   = mem_bus.rdata;
                    upd_dirty  = 1'b0;
                    next_state = cache_pkg::IDLE;
                end
            end
            cache_pkg::BYPASS: begin
                mem_bus.ren = proc_bus.ren;
                mem_bus.wen = proc_bus.wen;
                if (mem_done) begin
                    next_state = cache_pkg::IDLE;
                end
            end
            cache_pkg::FLUSH_SCAN: begin
                if (valid[line_cnt] && dirty[line_cnt]) begin
                    next_state = cache_pkg::FLUSH_WB;
                end else if (cnt_last) begin
                    next_state = cache_pkg::FLUSH_DONE;
                end else begin
                    cnt_next = line_cnt + 1'b1;
                end
            end
            cache_pkg::FLUSH_WB: begin
                mem_bus.addr  = {tags_q[wb_idx], wb_idx, 2'b00};
                mem_bus.wdata = data_q[wb_idx];
                mem_bus.wen   = 1'b1;
                if (mem_done) begin
                    // line stays valid, only the dirty bit drops.
                    upd_en    = 1'b1;
                    upd_idx   = wb_idx;
                    upd_tag   = tags_q[wb_idx];
                    upd_data  = data_q[wb_idx];
                    upd_dirty = 1'b0;
                    if (cnt_last) begin
                        next_state = cache_pkg::FLUSH_DONE;
                    end else begin
                        next_state = cache_pkg::FLUSH_SCAN;
                        cnt_next   = line_cnt + 1'b1;
                    end
                end
            end
            cache_pkg::FLUSH_DONE: begin
                next_state = cache_pkg::IDLE;
            end
            default: begin
                next_state = cache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state      <= cache_pkg::IDLE;
            line_cnt   <= '0;
            valid      <= '0;
            dirty      <= '0;
            byp_ready  <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            state      <= next_state;
            line_cnt   <= cnt_next;
            clear_done <= clear;
            if (upd_en) begin
                valid[upd_idx] <= 1'b1;
                dirty[upd_idx] <= upd_dirty;
            end
            // clear wins over any line update in the same cycle.
            if (clear) begin
                valid <= '0;
                dirty <= '0;
            end
            if (byp_capture) begin
                byp_ready <= 1'b1;
            end else if (byp_take) begin
                byp_ready <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (upd_en) begin
            tags_q[upd_idx] <= upd_tag;
            data_q[upd_idx] <= upd_data;
        end
        if (byp_capture) begin
            byp_data <= mem_bus.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/generic_bus_if.sv ====
/*
 * Single-word request/response bus.
 * The requester holds ren or wen until busy drops for one completion cycle.
 * cpu is the requester side, generic_bus the responder side.
 */

`timescale 1ns/100ps
`default_nettype none

interface generic_bus_if;

    cache_pkg::addr_t addr;
    cache_pkg::word_t wdata;
    cache_pkg::word_t rdata;
    logic             ren;
    logic             wen;
    logic             busy;

    modport cpu (
        output addr, wdata, ren, wen,
        input  rdata, busy
    );

    modport generic_bus (
        input  addr, wdata, ren, wen,
        output rdata, busy
    );

endinterface

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
/*
 * Two-to-one arbiter from the cache memory buses onto the external bus.
 * Data side wins a tie; a grant is held until memory completes the transaction.
 * The winner passes through combinationally, the loser sees busy.
 */

`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
    input  logic               CLK,
    input  logic               arst_n,
    generic_bus_if.generic_bus icache_mem_bus,
    generic_bus_if.generic_bus dcache_mem_bus,
    generic_bus_if.cpu         mem_bus
);

    logic i_req;
    logic d_req;
    logic sel_d;
    logic sel_req;
    logic owner_d;
    logic locked;

    assign i_req = icache_mem_bus.ren | icache_mem_bus.wen;
    assign d_req = dcache_mem_bus.ren | dcache_mem_bus.wen;

    // with nothing pending the data side is parked on the bus.
    assign sel_d   = locked ? owner_d : (d_req || !i_req);
    assign sel_req = sel_d ? d_req : i_req;

    always_comb begin
        if (sel_d) begin
            mem_bus.addr  = dcache_mem_bus.addr;
            mem_bus.wdata = dcache_mem_bus.wdata;
            mem_bus.ren   = dcache_mem_bus.ren;
            mem_bus.wen   = dcache_mem_bus.wen;
        end else begin
            mem_bus.addr  = icache_mem_bus.addr;
            mem_bus.wdata = icache_mem_bus.wdata;
            mem_bus.ren   = icache_mem_bus.ren;
            mem_bus.wen   = icache_mem_bus.wen;
        end
    end

    assign icache_mem_bus.rdata = mem_bus.rdata;
    assign dcache_mem_bus.rdata = mem_bus.rdata;
    assign icache_mem_bus.busy  = sel_d ? 1'b1 : mem_bus.busy;
    assign dcache_mem_bus.busy  = sel_d ? mem_bus.busy : 1'b1;

    // lock on a request that did not complete this cycle.
    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            owner_d <= 1'b1;
            locked  <= 1'b0;
        end else begin
            owner_d <= sel_d;
            locked  <= sel_req && mem_bus.busy;
        end
    end

endmodule

`default_nettype wire

// ==== logic/separate_caches.sv ====
/*
 * Split L1 arrangement: one instruction cache and one data cache.
 * Each cache gets its own core bus, memory bus and half of the control signals.
 */

`timescale 1ns/100ps
`default_nettype none

module separate_caches (
    input  logic               CLK,
    input  logic               arst_n,
    generic_bus_if.generic_bus icache_proc_bus,
    generic_bus_if.generic_bus dcache_proc_bus,
    generic_bus_if.cpu         icache_mem_bus,
    generic_bus_if.cpu         dcache_mem_bus,
    cache_control_if.caches    control,
    output logic               icache_miss,
    output logic               dcache_miss
);

    // instruction side, never written by the core.
    direct_mapped_cache icache (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .proc_bus   (icache_proc_bus),
        .mem_bus    (icache_mem_bus),
        .flush      (control.icache_flush),
        .clear      (control.icache_clear),
        .flush_done (control.iflush_done),
        .clear_done (control.iclear_done),
        .cache_miss (icache_miss)
    );

    direct_mapped_cache dcache (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .proc_bus   (dcache_proc_bus),
        .mem_bus    (dcache_mem_bus),
        .flush      (control.dcache_flush),
        .clear      (control.dcache_clear),
        .flush_done (control.dflush_done),
        .clear_done (control.dclear_done),
        .cache_miss (dcache_miss)
    );

endmodule

`default_nettype wire
